// File: common/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// instruction address space seen by the program counter
`define ADDR_WIDTH_MEM 16

// words written per external load block
`define ISA_DEPTH 64

// total cache size in words
`define TOTAL_ISA_DEPTH 128

// number of blocks the cache can hold
`define LOAD_BLOCKS (`TOTAL_ISA_DEPTH / `ISA_DEPTH)

// external byte address, interrupt vectors use this width
`define DDR_ADDR_WIDTH 28

`define INS_WIDTH 32
`define LOAD_CNT_WIDTH 10

`endif

// File: common/fetch_pkg.sv
`include "fetch_params.svh"

package fetch_pkg;

    // program counter states, encoded as in the older counter
    typedef enum logic [2:0]
    {
        START         = 3'd1,
        CNT_ADDR      = 3'd2,
        LOAD_JMP_ADDR = 3'd3,
        LOAD_RET_ADDR = 3'd4,
        LOAD_RET_END  = 3'd5
    } pc_state_e;

    // top nibble of every instruction word
    typedef enum logic [3:0]
    {
        OP_NOP   = 4'h0,
        OP_PRINT = 4'h1,
        OP_RET   = 4'h2
    } opcode_e;

    typedef struct packed
    {
        opcode_e                   opcode;
        logic [`INS_WIDTH-5:0]     operand;
    } ins_word_t;

    typedef struct packed
    {
        logic                      inited;
        logic                      rdy;
        logic [`LOAD_CNT_WIDTH-1:0] load_times;
    } cache_status_t;

    // one word written from external memory
    typedef struct packed
    {
        logic                      valid;
        logic [`ADDR_WIDTH_MEM-1:0] addr;
        ins_word_t                 data;
    } load_word_t;

endpackage

// File: ins_cache/ins_loader.sv
`timescale 1ns/1ns
`include "fetch_params.svh"

module ins_loader
    import fetch_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  load_word_t                  ext_wr,
    output load_word_t                  wr,
    output logic [`LOAD_CNT_WIDTH-1:0]  load_times
);

    localparam int BLK_W = $clog2(`ISA_DEPTH);

    logic                       wr_valid;
    logic [`ADDR_WIDTH_MEM-1:0] wr_addr;
    ins_word_t                  wr_data;
    logic                       blk_last;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            wr_valid <= 1'b0;
        end
        else
        begin
            wr_valid <= ext_wr.valid;
        end
    end

    always_ff @(posedge clk)
    begin
        wr_addr <= ext_wr.addr;
        wr_data <= ext_wr.data;
    end

    assign wr = '{valid: wr_valid, addr: wr_addr, data: wr_data};

    // last word of a block completes it
    assign blk_last = wr_valid && (wr_addr[BLK_W-1:0] == BLK_W'(`ISA_DEPTH - 1));

    // counted with the write so the cache sees data and count together
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            load_times <= '0;
        end
        else if (blk_last && (load_times < `LOAD_BLOCKS))
        begin
            load_times <= load_times + 1'b1;
        end
    end

endmodule

// File: ins_cache/ins_cache.sv
`timescale 1ns/1ns
`include "fetch_params.svh"

module ins_cache
    import fetch_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  load_word_t                  wr,
    input  logic [`LOAD_CNT_WIDTH-1:0]  load_times,
    input  logic [`ADDR_WIDTH_MEM-1:0]  addr_ins,
    output ins_word_t                   ins,
    output cache_status_t               status
);

    localparam int IDX_W = $clog2(`TOTAL_ISA_DEPTH);

    ins_word_t                  mem [`TOTAL_ISA_DEPTH];
    logic [`ADDR_WIDTH_MEM-1:0] addr_q;
    logic [`ADDR_WIDTH_MEM-1:0] loaded_end;
    logic                       rdy_q;
    logic                       inited_q;
    logic                       addr_loaded;

    assign loaded_end  = `ADDR_WIDTH_MEM'(load_times * `ISA_DEPTH);
    assign addr_loaded = (addr_ins < loaded_end);

    // writes beyond the array are dropped
    always_ff @(posedge clk)
    begin
        if (wr.valid && (wr.addr < `TOTAL_ISA_DEPTH))
        begin
            mem[wr.addr[IDX_W-1:0]] <= wr.data;
        end
    end

    always_ff @(posedge clk)
    begin
        ins <= mem[addr_ins[IDX_W-1:0]];
    end

    // rdy needs the address to sit still for one cycle
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            addr_q   <= '0;
            rdy_q    <= 1'b0;
            inited_q <= 1'b0;
        end
        else
        begin
            addr_q <= addr_ins;
            rdy_q  <= (addr_ins == addr_q) && addr_loaded;
            if (load_times != '0)
            begin
                inited_q <= 1'b1;
            end
        end
    end

    assign status = '{inited: inited_q, rdy: rdy_q, load_times: load_times};

endmodule

// File: src/ap_ctrl.sv
`timescale 1ns/1ns
`include "fetch_params.svh"

module ap_ctrl
    import fetch_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  ins_word_t                   ins,
    input  cache_status_t               status,
    input  logic [`ADDR_WIDTH_MEM-1:0]  addr_ins,
    input  logic                        intr,
    input  logic [`DDR_ADDR_WIDTH-1:0]  int_vector,
    input  logic                        print_data_finish,
    output logic                        ins_inp_valid,
    output logic                        ret_valid,
    output logic                        ret_addr_pc_rdy,
    output logic [`ADDR_WIDTH_MEM-1:0]  ret_addr_pc,
    output logic [`DDR_ADDR_WIDTH-1:0]  jmp_addr_pc
);

    logic       consumed;
    logic       ret_wait;
    logic [1:0] int_cnt;
    logic [1:0] ret_cnt;
    logic       fresh;
    logic       issue_nop;
    logic       issue_ret;
    logic       print_done;

    // a word is acted on once, and not while a jump or return is in flight
    assign fresh = status.inited & status.rdy & ~consumed & ~ret_wait
                 & ~intr & (int_cnt == 2'd0);

    always_comb
    begin
        issue_nop  = 1'b0;
        issue_ret  = 1'b0;
        print_done = 1'b0;
        if (fresh)
        begin
            case (ins.opcode)
                OP_PRINT: print_done = print_data_finish;
                OP_RET:   issue_ret  = 1'b1;
                default:  issue_nop  = 1'b1;
            endcase
        end
    end

    // int_cnt == 3 is the vector strobe, two cycles after the latch is set
    assign ins_inp_valid   = issue_nop | (int_cnt == 2'd3);
    assign ret_valid       = (ret_cnt != 2'd0);
    assign ret_addr_pc_rdy = (ret_cnt == 2'd3);

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            consumed <= 1'b0;
        end
        else if (!status.rdy)
        begin
            consumed <= 1'b0;
        end
        else if (issue_nop || issue_ret || print_done)
        begin
            consumed <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            int_cnt     <= 2'd0;
            ret_addr_pc <= '0;
        end
        else if (intr && (int_cnt == 2'd0))
        begin
            int_cnt     <= 2'd1;
            ret_addr_pc <= addr_ins;
        end
        else if (int_cnt != 2'd0)
        begin
            int_cnt <= int_cnt + 2'd1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (intr && (int_cnt == 2'd0))
        begin
            jmp_addr_pc <= int_vector;
        end
    end

    // three cycle return window, then hold off until the saved address is back
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            ret_cnt  <= 2'd0;
            ret_wait <= 1'b0;
        end
        else
        begin
            if (issue_ret)
            begin
                ret_cnt <= 2'd3;
            end
            else if (ret_cnt != 2'd0)
            begin
                ret_cnt <= ret_cnt - 2'd1;
            end

            if (issue_ret)
            begin
                ret_wait <= 1'b1;
            end
            else if ((ret_cnt == 2'd0) && (addr_ins == ret_addr_pc))
            begin
                ret_wait <= 1'b0;
            end
        end
    end

endmodule

// File: src/program_counter.sv
`timescale 1ns/1ns
`include "fetch_params.svh"

module program_counter
    import fetch_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        ins_inp_valid,
    input  logic                        ret_valid,
    input  logic                        intr,
    input  logic                        print_data_finish,
    input  logic                        ret_addr_pc_rdy,
    input  logic [`ADDR_WIDTH_MEM-1:0]  ret_addr_pc,
    input  logic [`DDR_ADDR_WIDTH-1:0]  jmp_addr_pc,
    input  cache_status_t               status,
    output logic [`ADDR_WIDTH_MEM-1:0]  addr_ins,
    output logic                        ins_finish
);

    // address shown while the interrupt vector is pending
    localparam logic [`ADDR_WIDTH_MEM-1:0] PARK_ADDR =
        {1'b1, {(`ADDR_WIDTH_MEM-1){1'b0}}};

    pc_state_e                  st_cur;
    pc_state_e                  st_nxt;
    logic                       int_set;
    logic                       ret_valid_q;
    logic                       ret_fall;
    logic                       step;
    logic [`ADDR_WIDTH_MEM-1:0] blk_end;
    logic [`ADDR_WIDTH_MEM-1:0] jmp_word;

    assign ret_fall = ret_valid_q & ~ret_valid;
    assign blk_end  = `ADDR_WIDTH_MEM'(status.load_times * `ISA_DEPTH);

    // byte address divided by 8
    assign jmp_word = jmp_addr_pc[`ADDR_WIDTH_MEM+2:3];

    // never step past the last loaded word
    assign step = (ins_inp_valid | print_data_finish)
                & ~ret_valid
                & (addr_ins < `TOTAL_ISA_DEPTH)
                & (addr_ins != blk_end);

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            st_cur      <= START;
            ret_valid_q <= 1'b0;
        end
        else
        begin
            st_cur      <= st_nxt;
            ret_valid_q <= ret_valid;
        end
    end

    // interrupt latch, cleared by the vector strobe
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            int_set <= 1'b0;
        end
        else if (intr)
        begin
            int_set <= 1'b1;
        end
        else if ((st_cur == LOAD_JMP_ADDR) && ins_inp_valid)
        begin
            int_set <= 1'b0;
        end
    end

    always_comb
    begin
        st_nxt = st_cur;
        case (st_cur)
            START:
            begin
                st_nxt = CNT_ADDR;
            end
            CNT_ADDR:
            begin
                if (int_set)
                begin
                    st_nxt = LOAD_JMP_ADDR;
                end
                else if (ret_valid)
                begin
                    st_nxt = LOAD_RET_ADDR;
                end
            end
            LOAD_JMP_ADDR:
            begin
                if (ins_inp_valid)
                begin
                    st_nxt = CNT_ADDR;
                end
            end
            LOAD_RET_ADDR:
            begin
                if (ret_fall)
                begin
                    st_nxt = LOAD_RET_END;
                end
            end
            LOAD_RET_END:
            begin
                if (status.rdy)
                begin
                    st_nxt = CNT_ADDR;
                end
            end
            default:
            begin
                st_nxt = START;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            addr_ins <= '0;
        end
        else
        begin
            case (st_cur)
                CNT_ADDR:
                begin
                    // the return address arrives as we leave for LOAD_RET_ADDR
                    if (ret_addr_pc_rdy)
                    begin
                        addr_ins <= ret_addr_pc - 1'b1;
                    end
                    else if (step)
                    begin
                        addr_ins <= addr_ins + 1'b1;
                    end
                end
                LOAD_JMP_ADDR:
                begin
                    if (ins_inp_valid)
                    begin
                        addr_ins <= jmp_word;
                    end
                    else
                    begin
                        addr_ins <= PARK_ADDR;
                    end
                end
                LOAD_RET_END:
                begin
                    // one step forward lands on the saved address
                    if (status.rdy)
                    begin
                        addr_ins <= addr_ins + 1'b1;
                    end
                end
                default:
                begin
                    addr_ins <= addr_ins;
                end
            endcase
        end
    end

    // rises with the step onto TOTAL_ISA_DEPTH and stays up
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            ins_finish <= 1'b0;
        end
        else if ((st_cur == CNT_ADDR) && step && (addr_ins == `TOTAL_ISA_DEPTH - 1))
        begin
            ins_finish <= 1'b1;
        end
    end

endmodule

// File: src/fetch_top.sv
`timescale 1ns/1ns
`include "fetch_params.svh"

module fetch_top
    import fetch_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  load_word_t                  ext_wr,
    input  logic                        intr,
    input  logic [`DDR_ADDR_WIDTH-1:0]  int_vector,
    input  logic                        print_data_finish,
    output logic [`ADDR_WIDTH_MEM-1:0]  addr_ins,
    output ins_word_t                   ins,
    output logic                        ins_finish,
    output logic                        ret_valid
);

    load_word_t                 wr;
    logic [`LOAD_CNT_WIDTH-1:0] load_times;
    cache_status_t              status;
    logic                       ins_inp_valid;
    logic                       ret_addr_pc_rdy;
    logic [`ADDR_WIDTH_MEM-1:0] ret_addr_pc;
    logic [`DDR_ADDR_WIDTH-1:0] jmp_addr_pc;

    ins_loader u_loader (
        .clk        (clk),
        .rst        (rst),
        .ext_wr     (ext_wr),
        .wr         (wr),
        .load_times (load_times)
    );

    ins_cache u_cache (
        .clk        (clk),
        .rst        (rst),
        .wr         (wr),
        .load_times (load_times),
        .addr_ins   (addr_ins),
        .ins        (ins),
        .status     (status)
    );

    ap_ctrl u_ctrl (
        .clk               (clk),
        .rst               (rst),
        .ins               (ins),
        .status            (status),
        .addr_ins          (addr_ins),
        .intr              (intr),
        .int_vector        (int_vector),
        .print_data_finish (print_data_finish),
        .ins_inp_valid     (ins_inp_valid),
        .ret_valid         (ret_valid),
        .ret_addr_pc_rdy   (ret_addr_pc_rdy),
        .ret_addr_pc       (ret_addr_pc),
        .jmp_addr_pc       (jmp_addr_pc)
    );

    program_counter u_pc (
        .clk               (clk),
        .rst               (rst),
        .ins_inp_valid     (ins_inp_valid),
        .ret_valid         (ret_valid),
        .intr              (intr),
        .print_data_finish (print_data_finish),
        .ret_addr_pc_rdy   (ret_addr_pc_rdy),
        .ret_addr_pc       (ret_addr_pc),
        .jmp_addr_pc       (jmp_addr_pc),
        .status            (status),
        .addr_ins          (addr_ins),
        .ins_finish        (ins_finish)
    );

endmodule

// File: sim/fetch_asserts.sv
`timescale 1ns/1ns
`include "fetch_params.svh"

module fetch_asserts
    import fetch_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  load_word_t                  ext_wr,
    input  logic [`ADDR_WIDTH_MEM-1:0]  addr_ins,
    input  ins_word_t                   ins,
    input  logic                        ins_finish,
    input  logic                        ret_valid,
    input  logic                        intr,
    input  logic [`DDR_ADDR_WIDTH-1:0]  int_vector,
    input  logic                        print_data_finish,
    input  logic                        ins_inp_valid,
    input  cache_status_t               status,
    input  pc_state_e                   pc_state
);

    localparam logic [`ADDR_WIDTH_MEM-1:0] PARK_ADDR = 16'h8000;
    localparam int IDX_W = $clog2(`TOTAL_ISA_DEPTH);

    int                         fail_cnt = 0;
    int                         loaded_end;
    logic [`ADDR_WIDTH_MEM-1:0] saved_addr;
    logic [`ADDR_WIDTH_MEM-1:0] vector_word;
    ins_word_t                  shadow [`TOTAL_ISA_DEPTH];
    ins_word_t                  fetch_exp;

    // last word the counter may reach with the blocks loaded so far
    assign loaded_end  = int'(status.load_times) * `ISA_DEPTH;
    assign vector_word = `ADDR_WIDTH_MEM'(int_vector / 8);
    assign fetch_exp   = shadow[addr_ins[IDX_W-1:0]];

    // words as written through the external port
    always_ff @(posedge clk)
    begin
        if (ext_wr.valid && (ext_wr.addr < `TOTAL_ISA_DEPTH))
        begin
            shadow[ext_wr.addr[IDX_W-1:0]] <= ext_wr.data;
        end
    end

    // address that was running when the interrupt came in
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            saved_addr <= '0;
        end
        else if (intr)
        begin
            saved_addr <= addr_ins;
        end
    end

    a_block_bound: assert property (@(posedge clk) disable iff (!rst)
        (pc_state == CNT_ADDR) |-> (int'(addr_ins) <= loaded_end))
    else
    begin
        fail_cnt++;
        $error("Error addr_ins 0x%h beyond loaded end 0x%h", $sampled(addr_ins),
               $sampled(loaded_end));
    end

    a_single_step: assert property (@(posedge clk) disable iff (!rst)
        ((pc_state == CNT_ADDR) && ($past(pc_state) == CNT_ADDR)
         && (addr_ins != $past(addr_ins)))
        |-> (addr_ins == $past(addr_ins) + 1'b1) && $past(ins_inp_valid || print_data_finish))
    else
    begin
        fail_cnt++;
        $error("Error addr_ins 0x%h after 0x%h without a single step", $sampled(addr_ins),
               $past(addr_ins));
    end

    // a settled ready address shows the word last written there
    a_fetch_word: assert property (@(posedge clk) disable iff (!rst)
        (status.rdy && (addr_ins == $past(addr_ins)) && (addr_ins < `TOTAL_ISA_DEPTH))
        |-> (ins == fetch_exp))
    else
    begin
        fail_cnt++;
        $error("Error ins 0x%h at addr_ins 0x%h, expected 0x%h", $sampled(ins),
               $sampled(addr_ins), $sampled(fetch_exp));
    end

    // parked while the vector strobe is pending, then on the vector word
    a_jump: assert property (@(posedge clk) disable iff (!rst)
        ((pc_state == LOAD_JMP_ADDR) && ins_inp_valid)
        |-> (addr_ins == PARK_ADDR) ##1 (addr_ins == vector_word))
    else
    begin
        fail_cnt++;
        $error("Error addr_ins 0x%h at vector strobe, expected 0x%h then 0x%h",
               $sampled(addr_ins), PARK_ADDR, $sampled(vector_word));
    end

    // one below the saved address when the return window closes
    a_return_low: assert property (@(posedge clk) disable iff (!rst)
        $fell(ret_valid) |-> (addr_ins == saved_addr - 1'b1))
    else
    begin
        fail_cnt++;
        $error("Error addr_ins 0x%h at ret_valid fall, expected 0x%h", $sampled(addr_ins),
               $sampled(saved_addr) - 1'b1);
    end

    a_return: assert property (@(posedge clk) disable iff (!rst)
        ((pc_state == LOAD_RET_END) && status.rdy) |=> (addr_ins == saved_addr))
    else
    begin
        fail_cnt++;
        $error("Error addr_ins 0x%h not back at saved 0x%h", $sampled(addr_ins),
               $sampled(saved_addr));
    end

    a_finish_addr: assert property (@(posedge clk) disable iff (!rst)
        $rose(ins_finish) |-> (addr_ins == `TOTAL_ISA_DEPTH))
    else
    begin
        fail_cnt++;
        $error("Error addr_ins 0x%h at ins_finish rise, expected 0x%h", $sampled(addr_ins),
               `ADDR_WIDTH_MEM'(`TOTAL_ISA_DEPTH));
    end

    a_finish_hold: assert property (@(posedge clk) disable iff (!rst)
        ins_finish |=> ins_finish)
    else
    begin
        fail_cnt++;
        $error("Error ins_finish 0x%h dropped after being set", $sampled(ins_finish));
    end

    a_reset: assert property (@(posedge clk)
        $rose(rst) |-> (addr_ins == '0) && !ins_finish)
    else
    begin
        fail_cnt++;
        $error("Error addr_ins 0x%h ins_finish 0x%h after reset, expected 0x0000 0x0",
               $sampled(addr_ins), $sampled(ins_finish));
    end

endmodule

// File: sim/fetch_tb.sv
`timescale 1ns/1ns
`include "fetch_params.svh"

module fetch_tb
    import fetch_pkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DLY    = 2;
    localparam int RET_SLOT     = 16;
    localparam int INT_AT       = 90;
    localparam int STALL_CYCLES = 30;
    localparam int WATCH_CYCLES = `TOTAL_ISA_DEPTH * 20 + 500;

    logic                       clk;
    logic                       rst;
    load_word_t                 ext_wr;
    logic                       intr;
    logic [`DDR_ADDR_WIDTH-1:0] int_vector;
    logic                       print_data_finish;
    logic [`ADDR_WIDTH_MEM-1:0] addr_ins;
    ins_word_t                  ins;
    logic                       ins_finish;
    logic                       ret_valid;
    ins_word_t                  prog [`TOTAL_ISA_DEPTH];
    int                         timeouts = 0;

    fetch_top uut (
        .clk               (clk),
        .rst               (rst),
        .ext_wr            (ext_wr),
        .intr              (intr),
        .int_vector        (int_vector),
        .print_data_finish (print_data_finish),
        .addr_ins          (addr_ins),
        .ins               (ins),
        .ins_finish        (ins_finish),
        .ret_valid         (ret_valid)
    );

    bind fetch_top fetch_asserts u_asserts (
        .clk               (clk),
        .rst               (rst),
        .ext_wr            (ext_wr),
        .addr_ins          (addr_ins),
        .ins               (ins),
        .ins_finish        (ins_finish),
        .ret_valid         (ret_valid),
        .intr              (intr),
        .int_vector        (int_vector),
        .print_data_finish (print_data_finish),
        .ins_inp_valid     (ins_inp_valid),
        .status            (status),
        .pc_state          (u_pc.st_cur)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // random NOP/PRINT mix, NOPs around the return slot and the interrupt point
    function automatic void build_program();
        for (int i = 0; i < `TOTAL_ISA_DEPTH; i++)
        begin
            prog[i].opcode  = ($urandom_range(3) == 0) ? OP_PRINT : OP_NOP;
            prog[i].operand = (`INS_WIDTH-4)'($urandom());
            if ((i == RET_SLOT) || ((i >= INT_AT - 6) && (i <= INT_AT + 6)))
            begin
                prog[i].opcode = OP_NOP;
            end
        end
    endfunction

    task automatic write_word(input int addr, input ins_word_t data);
        @(posedge clk);
        #DRIVE_DLY;
        ext_wr = '{valid: 1'b1, addr: `ADDR_WIDTH_MEM'(addr), data: data};
    endtask

    task automatic load_block(input int blk);
        for (int i = 0; i < `ISA_DEPTH; i++)
        begin
            write_word(blk * `ISA_DEPTH + i, prog[blk * `ISA_DEPTH + i]);
        end
        @(posedge clk);
        #DRIVE_DLY;
        ext_wr.valid = 1'b0;
    endtask

    task automatic wait_addr(input int target);
        do
            @(negedge clk);
        while (int'(addr_ins) != target);
    endtask

    task automatic finish_run();
        int errs;
        errs = uut.u_asserts.fail_cnt;
        $display("assertion failures: %0d, timeouts: %0d", errs, timeouts);
        if ((errs == 0) && (timeouts == 0))
        begin
            $display("PASS: all tests");
        end
        else
        begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    // answers each ready PRINT word with a done pulse after a random gap
    initial
    begin : serve_prints
        int gap;
        forever
        begin
            @(negedge clk);
            if (rst && uut.status.rdy && (ins.opcode == OP_PRINT))
            begin
                gap = $urandom_range(3);
                repeat (gap) @(posedge clk);
                @(posedge clk);
                #DRIVE_DLY print_data_finish = 1'b1;
                @(posedge clk);
                #DRIVE_DLY print_data_finish = 1'b0;
                do
                    @(negedge clk);
                while (uut.status.rdy);
            end
        end
    end

    initial
    begin
        #(WATCH_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not complete", WATCH_CYCLES);
        timeouts = timeouts + 1;
        finish_run();
    end

    initial
    begin
        void'($urandom(86));
        rst               = 1'b0;
        ext_wr            = '0;
        intr              = 1'b0;
        int_vector        = `DDR_ADDR_WIDTH'(RET_SLOT * 8);
        print_data_finish = 1'b0;
        build_program();
        repeat (5) @(posedge clk);
        #DRIVE_DLY rst = 1'b1;

        // only block 0, the counter has to park at its end
        load_block(0);
        wait_addr(`ISA_DEPTH);
        repeat (STALL_CYCLES) @(posedge clk);

        // handler is a single RET at the vector target
        write_word(RET_SLOT, '{opcode: OP_RET, operand: '0});
        load_block(1);

        wait_addr(INT_AT);
        @(posedge clk);
        #DRIVE_DLY intr = 1'b1;
        @(posedge clk);
        #DRIVE_DLY intr = 1'b0;

        do
            @(negedge clk);
        while (!ins_finish);
        repeat (10) @(posedge clk);
        finish_run();
    end

endmodule

// File: sources.f
+incdir+common
common/fetch_pkg.sv
ins_cache/ins_loader.sv
ins_cache/ins_cache.sv
src/ap_ctrl.sv
src/program_counter.sv
src/fetch_top.sv
sim/fetch_asserts.sv
sim/fetch_tb.sv
